// File: src/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // funct3 of the ALU operations, shared by register and immediate forms
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // funct3 of the branches
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // The two legal funct7 values, ALT selects SUB and SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

endpackage

`default_nettype wire

// File: src/rv_ctrl_pkg.sv
`default_nettype none

package rv_ctrl_pkg;

    // Core widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // ALU operation select
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b0001,
        ALU_AND  = 4'b0010,
        ALU_OR   = 4'b0011,
        ALU_SLL  = 4'b0100,
        ALU_SLT  = 4'b0101,
        ALU_SRL  = 4'b0110,
        ALU_SLTU = 4'b0111,
        ALU_XOR  = 4'b1000,
        ALU_SRA  = 4'b1001
    } alu_op_e;

    // Immediate format
    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_J = 3'b011,
        IMM_U = 3'b100
    } imm_src_e;

    // Register writeback source
    typedef enum logic [1:0] {
        WB_ALU   = 2'b00,
        WB_MEM   = 2'b01,
        WB_PC4   = 2'b10,
        WB_ADDER = 2'b11
    } wb_src_e;

    // Base operand of the second adder
    typedef enum logic [1:0] {
        ADD_PC   = 2'b00,
        ADD_ZERO = 2'b01,
        ADD_RS1  = 2'b10
    } add_src_e;

endpackage

`default_nettype wire

// File: src/control.sv
`timescale 1ns/1ps
`default_nettype none

module control (
    input  rv_isa_pkg::opcode_e  op,
    input  logic [2:0]           func3,
    input  logic [6:0]           func7,
    input  logic                 alu_zero,
    input  logic                 alu_last_bit,
    output rv_ctrl_pkg::alu_op_e alu_control,
    output rv_ctrl_pkg::imm_src_e imm_source,
    output logic                 mem_write,
    output logic                 reg_write,
    output logic                 alu_source,
    output rv_ctrl_pkg::wb_src_e write_back_source,
    output logic                 pc_source,
    output rv_ctrl_pkg::add_src_e second_add_source
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    // How the ALU decoder picks its operation
    typedef enum logic [1:0] {
        DEC_MEM,
        DEC_FUNCT,
        DEC_BRANCH
    } alu_dec_e;

    alu_dec_e alu_dec;
    logic     branch;
    logic     jump;
    logic     take_branch;

    // Main decoder
    always_comb begin
        reg_write         = 1'b0;
        mem_write         = 1'b0;
        imm_source        = IMM_I;
        alu_source        = 1'b0;
        write_back_source = WB_ALU;
        second_add_source = ADD_PC;
        alu_dec           = DEC_MEM;
        branch            = 1'b0;
        jump              = 1'b0;
        case (op)
            OP_LOAD: begin
                reg_write         = 1'b1;
                alu_source        = 1'b1;
                write_back_source = WB_MEM;
            end
            OP_IMM: begin
                alu_source = 1'b1;
                alu_dec    = DEC_FUNCT;
                // Shift immediates carry a funct7 in the upper bits,
                // only the legal encodings may write back
                if (func3 == F3_SLL) begin
                    reg_write = (func7 == F7_BASE);
                end else if (func3 == F3_SR) begin
                    reg_write = (func7 == F7_BASE) || (func7 == F7_ALT);
                end else begin
                    reg_write = 1'b1;
                end
            end
            OP_STORE: begin
                mem_write  = 1'b1;
                imm_source = IMM_S;
                alu_source = 1'b1;
            end
            OP_REG: begin
                reg_write = 1'b1;
                alu_dec   = DEC_FUNCT;
            end
            OP_BRANCH: begin
                imm_source = IMM_B;
                alu_dec    = DEC_BRANCH;
                branch     = 1'b1;
            end
            OP_JAL: begin
                reg_write         = 1'b1;
                imm_source        = IMM_J;
                write_back_source = WB_PC4;
                jump              = 1'b1;
            end
            OP_JALR: begin
                reg_write         = 1'b1;
                write_back_source = WB_PC4;
                second_add_source = ADD_RS1;
                jump              = 1'b1;
            end
            OP_LUI: begin
                reg_write         = 1'b1;
                imm_source        = IMM_U;
                write_back_source = WB_ADDER;
                second_add_source = ADD_ZERO;
            end
            OP_AUIPC: begin
                reg_write         = 1'b1;
                imm_source        = IMM_U;
                write_back_source = WB_ADDER;
            end
            default: begin
                // Unknown opcode leaves registers and memory untouched
                reg_write = 1'b0;
            end
        endcase
    end

    // ALU decoder
    always_comb begin
        alu_control = ALU_ADD;
        case (alu_dec)
            DEC_FUNCT: begin
                case (func3)
                    // SUB only exists in the register form
                    F3_ADD:  alu_control = (op == OP_REG && func7[5]) ? ALU_SUB : ALU_ADD;
                    F3_SLL:  alu_control = ALU_SLL;
                    F3_SLT:  alu_control = ALU_SLT;
                    F3_SLTU: alu_control = ALU_SLTU;
                    F3_XOR:  alu_control = ALU_XOR;
                    F3_SR:   alu_control = func7[5] ? ALU_SRA : ALU_SRL;
                    F3_OR:   alu_control = ALU_OR;
                    F3_AND:  alu_control = ALU_AND;
                endcase
            end
            DEC_BRANCH: begin
                case (func3)
                    F3_BEQ, F3_BNE:   alu_control = ALU_SUB;
                    F3_BLT, F3_BGE:   alu_control = ALU_SLT;
                    F3_BLTU, F3_BGEU: alu_control = ALU_SLTU;
                    default:          alu_control = ALU_ADD;
                endcase
            end
            default: alu_control = ALU_ADD;
        endcase
    end

    // Branch condition from the ALU flags
    always_comb begin
        case (func3)
            F3_BEQ:           take_branch = alu_zero;
            F3_BNE:           take_branch = ~alu_zero;
            F3_BLT, F3_BLTU:  take_branch = alu_last_bit;
            F3_BGE, F3_BGEU:  take_branch = ~alu_last_bit;
            default:          take_branch = 1'b0;
        endcase
    end

    assign pc_source = (take_branch & branch) | jump;

endmodule

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [rv_ctrl_pkg::XLEN-1:0] a,
    input  logic [rv_ctrl_pkg::XLEN-1:0] b,
    input  rv_ctrl_pkg::alu_op_e         alu_control,
    output logic [rv_ctrl_pkg::XLEN-1:0] result,
    output logic                         zero,
    output logic                         last_bit
);
    import rv_ctrl_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (alu_control)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            // Compares give 0 or 1
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
            default:  result = '0;
        endcase
    end

    // Equality for BEQ/BNE comes from SUB
    assign zero     = (result == '0);
    assign last_bit = result[0];

endmodule

`default_nettype wire

// File: src/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [rv_ctrl_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [rv_ctrl_pkg::REG_ADDR_W-1:0] rs2_addr,
    input  logic [rv_ctrl_pkg::REG_ADDR_W-1:0] rd_addr,
    input  logic [rv_ctrl_pkg::XLEN-1:0]       rd_data,
    input  logic                               rd_we,
    output logic [rv_ctrl_pkg::XLEN-1:0]       rs1_data,
    output logic [rv_ctrl_pkg::XLEN-1:0]       rs2_data
);
    import rv_ctrl_pkg::*;

    logic [XLEN-1:0] regs [0:(1 << REG_ADDR_W)-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < (1 << REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // x0 always reads as zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// File: src/imm_extend.sv
`timescale 1ns/1ps
`default_nettype none

module imm_extend (
    input  logic [24:0]                  instr_bits,
    input  rv_ctrl_pkg::imm_src_e        imm_source,
    output logic [rv_ctrl_pkg::XLEN-1:0] imm
);
    import rv_ctrl_pkg::*;

    // instr_bits[k] is instruction bit k+7, the sign sits in bit 24
    logic sign;

    assign sign = instr_bits[24];

    always_comb begin
        case (imm_source)
            IMM_I: imm = {{20{sign}}, instr_bits[24:13]};
            IMM_S: imm = {{20{sign}}, instr_bits[24:18], instr_bits[4:0]};
            IMM_B: imm = {{20{sign}}, instr_bits[0], instr_bits[23:18],
                          instr_bits[4:1], 1'b0};
            IMM_J: imm = {{12{sign}}, instr_bits[12:5], instr_bits[13],
                          instr_bits[23:14], 1'b0};
            // Upper immediate, low 12 bits zero
            IMM_U: imm = {instr_bits[24:5], 12'b0};
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [31:0]                  instr,
    input  logic [rv_ctrl_pkg::XLEN-1:0] data_rdata,
    output logic [rv_ctrl_pkg::XLEN-1:0] pc,
    output logic [rv_ctrl_pkg::XLEN-1:0] data_addr,
    output logic [rv_ctrl_pkg::XLEN-1:0] data_wdata,
    output logic                         data_we
);
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    // Instruction fields
    opcode_e               op;
    logic [2:0]            func3;
    logic [6:0]            func7;
    logic [REG_ADDR_W-1:0] rs1_idx;
    logic [REG_ADDR_W-1:0] rs2_idx;
    logic [REG_ADDR_W-1:0] rd_idx;

    // Decoder outputs
    alu_op_e  alu_control;
    imm_src_e imm_source;
    logic     mem_write;
    logic     reg_write;
    logic     alu_source;
    wb_src_e  write_back_source;
    logic     pc_source;
    add_src_e second_add_source;

    logic            alu_zero;
    logic            alu_last_bit;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] wb_data;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] add_base;
    logic [XLEN-1:0] add_result;
    logic [XLEN-1:0] jump_target;
    logic [XLEN-1:0] pc_next;

    assign op      = opcode_e'(instr[6:0]);
    assign rd_idx  = instr[11:7];
    assign func3   = instr[14:12];
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];
    assign func7   = instr[31:25];

    control u_control (
        .op                (op),
        .func3             (func3),
        .func7             (func7),
        .alu_zero          (alu_zero),
        .alu_last_bit      (alu_last_bit),
        .alu_control       (alu_control),
        .imm_source        (imm_source),
        .mem_write         (mem_write),
        .reg_write         (reg_write),
        .alu_source        (alu_source),
        .write_back_source (write_back_source),
        .pc_source         (pc_source),
        .second_add_source (second_add_source)
    );

    regfile u_regfile (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_idx),
        .rs2_addr (rs2_idx),
        .rd_addr  (rd_idx),
        .rd_data  (wb_data),
        .rd_we    (reg_write & rst_n),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    imm_extend u_imm_extend (
        .instr_bits (instr[31:7]),
        .imm_source (imm_source),
        .imm        (imm)
    );

    assign alu_b = alu_source ? imm : rs2_data;

    alu u_alu (
        .a           (rs1_data),
        .b           (alu_b),
        .alu_control (alu_control),
        .result      (alu_result),
        .zero        (alu_zero),
        .last_bit    (alu_last_bit)
    );

    // Second adder for branch, jump and upper immediate targets
    always_comb begin
        case (second_add_source)
            ADD_ZERO: add_base = '0;
            ADD_RS1:  add_base = rs1_data;
            default:  add_base = pc;
        endcase
    end

    assign add_result = add_base + imm;

    // JALR drops bit 0 of its target
    assign jump_target = (second_add_source == ADD_RS1) ? {add_result[XLEN-1:1], 1'b0}
                                                        : add_result;

    always_comb begin
        case (write_back_source)
            WB_MEM:   wb_data = data_rdata;
            WB_PC4:   wb_data = pc_plus4;
            WB_ADDER: wb_data = add_result;
            default:  wb_data = alu_result;
        endcase
    end

    assign pc_plus4 = pc + XLEN'(4);
    assign pc_next  = pc_source ? jump_target : pc_plus4;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // Data memory port
    assign data_addr  = alu_result;
    assign data_wdata = rs2_data;
    assign data_we    = mem_write & rst_n;

endmodule

`default_nettype wire

// File: dv/rv_core_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core_assertions (
    input logic                         clk,
    input logic                         rst_n,
    input logic [rv_ctrl_pkg::XLEN-1:0] pc,
    input logic                         data_we
);
    import rv_ctrl_pkg::*;

    // No store reaches memory in reset
    no_store_in_reset: assert property (@(posedge clk) !rst_n |-> !data_we)
        else $error("data_we is high while rst_n is low");

    pc_word_aligned: assert property (@(posedge clk) rst_n |-> pc[1:0] == 2'b00)
        else $error("pc is not word-aligned");

    // First cycle out of reset starts at the reset vector
    pc_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> pc == RESET_PC)
        else $error("pc is not at the reset address after reset");

endmodule

bind rv_core rv_core_assertions u_assertions (
    .clk     (clk),
    .rst_n   (rst_n),
    .pc      (pc),
    .data_we (data_we)
);

`default_nettype wire

// File: dv/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    localparam int         CLK_PERIOD = 40;
    localparam logic [2:0] F3_WORD    = 3'b010;
    localparam int         N_ALU      = 400;
    localparam int         N_MEM      = 100;
    localparam int         N_BRANCH   = 120;
    localparam int         N_JUMP     = 40;
    localparam int         N_UNUSED   = 50;
    // Reset, register preload and one cycle per issued instruction
    localparam int CYCLE_LIMIT = 2 + 31 + 2 * N_ALU + 2 * N_MEM + N_BRANCH + 8 * N_JUMP
                                 + 2 * N_UNUSED + 50;

    logic            clk = 1'b0;
    logic            rst_n;
    logic [31:0]     instr;
    logic [XLEN-1:0] data_rdata;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] data_addr;
    logic [XLEN-1:0] data_wdata;
    logic            data_we;

    // Instruction-set model state and its predictions
    logic [XLEN-1:0] model_regs [0:31];
    logic [XLEN-1:0] model_pc;
    logic            exp_we;
    logic            addr_valid;
    logic [XLEN-1:0] exp_addr;
    logic [XLEN-1:0] exp_wdata;
    logic [31:0]     lfsr = 32'h4118_cdde;
    logic [2:0]      branch_f3 [0:5] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    int              cycles = 0;
    int              checks = 0;
    int              errors = 0;
    int              total_checks = 0;
    int              total_errors = 0;

    rv_core DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .data_rdata (data_rdata),
        .pc         (pc),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_we    (data_we)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // Galois LFSR stepped once per bit taken with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    // RV32I instruction formats
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [6:0] op, input logic [11:0] imm,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[11:5], rs2, rs1, f3, off[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function automatic logic [31:0] u_type(input logic [6:0] op, input logic [19:0] imm,
                                           input logic [4:0] rd);
        return {imm, rd, op};
    endfunction

    function automatic logic known_opcode(input logic [6:0] opc);
        return opc == OP_LOAD || opc == OP_IMM || opc == OP_STORE || opc == OP_REG
            || opc == OP_BRANCH || opc == OP_JAL || opc == OP_JALR || opc == OP_LUI
            || opc == OP_AUIPC;
    endfunction

    // Reference arithmetic where alt picks SUB or SRA
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            F3_ADD:  return alt ? a - b : a + b;
            F3_SLL:  return a << b[4:0];
            F3_SLT:  return {31'b0, $signed(a) < $signed(b)};
            F3_SLTU: return {31'b0, a < b};
            F3_XOR:  return a ^ b;
            F3_OR:   return a | b;
            F3_AND:  return a & b;
            default: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Executes one instruction in the model and sets the expected bus values
    task automatic predict(input logic [31:0] ins, input logic [31:0] rdata);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] imm_u;
        logic [31:0] result;
        logic [31:0] next_pc;
        logic        write;
        logic        taken;

        opc        = ins[6:0];
        f3         = ins[14:12];
        f7         = ins[31:25];
        a          = model_regs[ins[19:15]];
        b          = model_regs[ins[24:20]];
        imm_i      = {{20{ins[31]}}, ins[31:20]};
        imm_s      = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b      = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j      = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        imm_u      = {ins[31:12], 12'b0};
        write      = 1'b0;
        taken      = 1'b0;
        result     = '0;
        next_pc    = model_pc + 32'd4;
        exp_we     = 1'b0;
        addr_valid = 1'b0;
        exp_addr   = '0;
        exp_wdata  = b;
        case (opc)
            OP_REG: begin
                write  = 1'b1;
                result = alu_ref(f3, f7[5], a, b);
            end
            OP_IMM: begin
                // Immediate shifts need a legal funct7
                if (f3 == F3_SLL) begin
                    write = (f7 == F7_BASE);
                end else if (f3 == F3_SR) begin
                    write = (f7 == F7_BASE) || (f7 == F7_ALT);
                end else begin
                    write = 1'b1;
                end
                result = alu_ref(f3, (f3 == F3_SR) && f7[5], a, imm_i);
            end
            OP_LOAD: begin
                write      = 1'b1;
                result     = rdata;
                addr_valid = 1'b1;
                exp_addr   = a + imm_i;
            end
            OP_STORE: begin
                exp_we     = 1'b1;
                addr_valid = 1'b1;
                exp_addr   = a + imm_s;
            end
            OP_BRANCH: begin
                case (f3)
                    F3_BEQ:  taken = (a == b);
                    F3_BNE:  taken = (a != b);
                    F3_BLT:  taken = ($signed(a) < $signed(b));
                    F3_BGE:  taken = ($signed(a) >= $signed(b));
                    F3_BLTU: taken = (a < b);
                    F3_BGEU: taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    next_pc = model_pc + imm_b;
                end
            end
            OP_JAL: begin
                write   = 1'b1;
                result  = model_pc + 32'd4;
                next_pc = model_pc + imm_j;
            end
            OP_JALR: begin
                write   = 1'b1;
                result  = model_pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            OP_LUI: begin
                write  = 1'b1;
                result = imm_u;
            end
            OP_AUIPC: begin
                write  = 1'b1;
                result = model_pc + imm_u;
            end
            default: begin
                write = 1'b0;
            end
        endcase
        if (write && ins[11:7] != 5'd0) begin
            model_regs[ins[11:7]] = result;
        end
        model_pc = next_pc;
    endtask

    // Starts and ends on a falling edge
    task automatic issue(input logic [31:0] ins);
        logic [31:0] rdata;
        rdata = rand_bits(32);
        check_value("pc", pc, model_pc);
        rst_n      = 1'b1;
        instr      = ins;
        data_rdata = rdata;
        #(CLK_PERIOD / 4);
        predict(ins, rdata);
        check_value("data_we", {31'b0, data_we}, {31'b0, exp_we});
        if (addr_valid) begin
            check_value("data_addr", data_addr, exp_addr);
        end
        check_value("data_wdata", data_wdata, exp_wdata);
        @(negedge clk);
    endtask

    // Exposes a register on data_wdata
    task automatic store_reg(input logic [4:0] rs2);
        issue(s_type({10'(rand_bits(10)), 2'b00}, rs2, 5'd0, F3_WORD));
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d checks, %0d errors", name, checks, errors);
        total_checks += checks;
        total_errors += errors;
        checks = 0;
        errors = 0;
    endtask

    initial begin
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [6:0]  opc;
        logic [4:0]  s5;
        logic [6:0]  s7;
        logic [8:0]  s9;

        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        model_pc   = RESET_PC;
        rst_n      = 1'b0;
        instr      = s_type(12'h010, 5'd1, 5'd0, F3_WORD);
        data_rdata = '0;

        // A store sits on the bus during reset
        #(CLK_PERIOD / 4);
        check_value("data_we", {31'b0, data_we}, 32'd0);
        @(negedge clk);
        check_value("data_we", {31'b0, data_we}, 32'd0);
        @(negedge clk);
        check_value("data_we", {31'b0, data_we}, 32'd0);
        check_value("pc", pc, RESET_PC);
        end_test("reset");

        // Random contents for x1 to x31
        for (int r = 1; r < 32; r++) begin
            issue(i_type(OP_LOAD, 12'(rand_bits(12)), 5'(rand_bits(5)), F3_WORD, 5'(r)));
        end
        for (int n = 0; n < N_ALU; n++) begin
            rd  = 5'(rand_bits(5));
            rs1 = 5'(rand_bits(5));
            rs2 = 5'(rand_bits(5));
            f3  = 3'(rand_bits(3));
            f7  = F7_BASE;
            if (rand_bits(1) == 1) begin
                if ((f3 == F3_ADD || f3 == F3_SR) && rand_bits(1) == 1) begin
                    f7 = F7_ALT;
                end
                issue(r_type(f7, rs2, rs1, f3, rd));
            end else if (f3 == F3_SLL || f3 == F3_SR) begin
                // One shift in four gets a random, mostly illegal funct7
                if (rand_bits(2) == 0) begin
                    f7 = 7'(rand_bits(7));
                end else if (f3 == F3_SR && rand_bits(1) == 1) begin
                    f7 = F7_ALT;
                end
                issue(i_type(OP_IMM, {f7, rs2}, rs1, f3, rd));
            end else begin
                issue(i_type(OP_IMM, 12'(rand_bits(12)), rs1, f3, rd));
            end
            store_reg(rd);
        end
        end_test("alu");

        for (int n = 0; n < N_MEM; n++) begin
            rd = 5'(rand_bits(5));
            issue(i_type(OP_LOAD, 12'(rand_bits(12)), 5'(rand_bits(5)), F3_WORD, rd));
            issue(s_type(12'(rand_bits(12)), rd, 5'(rand_bits(5)), F3_WORD));
        end
        end_test("load_store");

        for (int n = 0; n < N_BRANCH; n++) begin
            f3  = branch_f3[rand_bits(3) % 6];
            rs1 = 5'(rand_bits(5));
            rs2 = (rand_bits(2) == 0) ? rs1 : 5'(rand_bits(5));
            s5  = 5'(rand_bits(5));
            issue(b_type({{6{s5[4]}}, s5, 2'b00}, rs2, rs1, f3));
        end
        end_test("branch");

        for (int n = 0; n < N_JUMP; n++) begin
            rd = 5'(rand_bits(5));
            s7 = 7'(rand_bits(7));
            issue(j_type({{12{s7[6]}}, s7, 2'b00}, rd));
            store_reg(rd);
            // Link register as base with a random bit 0 in the offset
            rs1 = rd;
            rd  = 5'(rand_bits(5));
            s9  = 9'(rand_bits(9));
            issue(i_type(OP_JALR, {s9[8], s9, 1'b0, 1'(rand_bits(1))}, rs1, 3'b000, rd));
            store_reg(rd);
            rd = 5'(rand_bits(5));
            issue(u_type(OP_LUI, 20'(rand_bits(20)), rd));
            store_reg(rd);
            rd = 5'(rand_bits(5));
            issue(u_type(OP_AUIPC, 20'(rand_bits(20)), rd));
            store_reg(rd);
        end
        end_test("jump_upper");

        for (int n = 0; n < N_UNUSED; n++) begin
            opc = 7'(rand_bits(7));
            while (known_opcode(opc)) begin
                opc = 7'(rand_bits(7));
            end
            rd = 5'(rand_bits(5));
            issue({12'(rand_bits(12)), rd, 3'(rand_bits(3)), rd, opc});
            store_reg(rd);
        end
        check_value("pc", pc, model_pc);
        end_test("unused_op");

        $display("total: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
src/rv_isa_pkg.sv
src/rv_ctrl_pkg.sv
src/control.sv
src/alu.sv
src/regfile.sv
src/imm_extend.sv
src/rv_core.sv
dv/rv_core_assertions.sv
dv/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rv_core -f compile.f -o sim_rv_core

if ! ./obj_dir/sim_rv_core > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
    exit 1
fi
exit 0
